/* Makefile */
# Verilator build and run for the pipelined core

VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FILELIST  ?= mipsCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing -Wno-fatal

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  mipsIsaPkg::instrWord  instrD,
    input  mipsPipePkg::dataWord  pcPlus4D,
    input  logic                  regWriteW,
    input  mipsPipePkg::regIdx    writeRegW,
    input  mipsPipePkg::dataWord  resultW,
    input  mipsPipePkg::dataWord  aluOutM,
    input  logic                  forwardAD,
    input  logic                  forwardBD,
    input  logic                  flushE,
    output logic                  pcSrcD,
    output mipsPipePkg::dataWord  pcBranchD,
    output mipsPipePkg::regIdx    rsD,
    output mipsPipePkg::regIdx    rtD,
    output logic                  branchD,
    output logic                  regWriteE,
    output logic                  memToRegE,
    output logic                  memWriteE,
    output logic                  aluSrcE,
    output logic                  regDstE,
    output mipsPipePkg::aluOp     aluControlE,
    output mipsPipePkg::dataWord  rd1E,
    output mipsPipePkg::dataWord  rd2E,
    output mipsPipePkg::dataWord  signImmE,
    output mipsPipePkg::regIdx    rsE,
    output mipsPipePkg::regIdx    rtE,
    output mipsPipePkg::regIdx    rdE
);

    mipsIsaPkg::opcode    opD;
    mipsIsaPkg::funct     fnD;
    mipsIsaPkg::imm16     immD;
    mipsPipePkg::regIdx   rdD;
    mipsPipePkg::dataWord signImmD;
    mipsPipePkg::dataWord rd1D, rd2D;
    mipsPipePkg::dataWord cmpA, cmpB;
    mipsPipePkg::dataWord rf [32];
    mipsPipePkg::aluOp    aluControlD;
    logic regWriteD, memToRegD, memWriteD, aluSrcD, regDstD;

    assign opD  = mipsIsaPkg::opcode'(instrD[31:26]);
    assign fnD  = mipsIsaPkg::funct'(instrD[5:0]);
    assign rsD  = instrD[25:21];
    assign rtD  = instrD[20:16];
    assign rdD  = instrD[15:11];
    assign immD = instrD[15:0];
    assign signImmD = {{16{immD[15]}}, immD};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        {regWriteD, memToRegD, memWriteD, aluSrcD, regDstD, branchD} = '0;
        aluControlD = mipsPipePkg::aluAdd;
        case (opD)
            mipsIsaPkg::opRType: begin
                regWriteD = 1'b1;
                regDstD   = 1'b1;
                case (fnD)
                    mipsIsaPkg::fnSub: aluControlD = mipsPipePkg::aluSub;
                    mipsIsaPkg::fnAnd: aluControlD = mipsPipePkg::aluAnd;
                    mipsIsaPkg::fnOr:  aluControlD = mipsPipePkg::aluOr;
                    mipsIsaPkg::fnSlt: aluControlD = mipsPipePkg::aluSlt;
                    default:           aluControlD = mipsPipePkg::aluAdd;
                endcase
            end
            mipsIsaPkg::opAddi: {regWriteD, aluSrcD} = 2'b11;
            mipsIsaPkg::opLw:   {regWriteD, aluSrcD, memToRegD} = 3'b111;
            mipsIsaPkg::opSw:   {aluSrcD, memWriteD} = 2'b11;
            mipsIsaPkg::opBeq:  branchD = 1'b1;
            default: ;
        endcase
    end

    // register file, r0 reads as zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) rf[i] <= '0;
        end else if (regWriteW && writeRegW != '0) begin
            rf[writeRegW] <= resultW;
        end
    end

    assign rd1D = (rsD == '0) ? '0 : (regWriteW && writeRegW == rsD) ? resultW : rf[rsD];
    assign rd2D = (rtD == '0) ? '0 : (regWriteW && writeRegW == rtD) ? resultW : rf[rtD];

    // early branch compare
    assign cmpA      = forwardAD ? aluOutM : rd1D;
    assign cmpB      = forwardBD ? aluOutM : rd2D;
    assign pcSrcD    = branchD && (cmpA == cmpB);
    assign pcBranchD = pcPlus4D + {signImmD[29:0], 2'b00};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ID/EX register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rstN || flushE) begin
            {regWriteE, memToRegE, memWriteE} <= '0; // bubble
        end else begin
            {regWriteE, memToRegE, memWriteE} <= {regWriteD, memToRegD, memWriteD};
        end
    end

    always_ff @(posedge clk) begin
        aluSrcE     <= aluSrcD;
        regDstE     <= regDstD;
        aluControlE <= aluControlD;
        rd1E        <= rd1D;
        rd2E        <= rd2D;
        signImmE    <= signImmD;
        rsE         <= rsD;
        rtE         <= rtD;
        rdE         <= rdD;
    end

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  regWriteE,
    input  logic                  memToRegE,
    input  logic                  memWriteE,
    input  logic                  aluSrcE,
    input  logic                  regDstE,
    input  mipsPipePkg::aluOp     aluControlE,
    input  mipsPipePkg::dataWord  rd1E,
    input  mipsPipePkg::dataWord  rd2E,
    input  mipsPipePkg::dataWord  signImmE,
    input  mipsPipePkg::regIdx    rtE,
    input  mipsPipePkg::regIdx    rdE,
    input  mipsPipePkg::fwdSel    forwardAE,
    input  mipsPipePkg::fwdSel    forwardBE,
    input  mipsPipePkg::dataWord  resultW,
    output logic                  regWriteM,
    output logic                  memToRegM,
    output logic                  memWriteM,
    output mipsPipePkg::dataWord  aluOutM,
    output mipsPipePkg::dataWord  writeDataM,
    output mipsPipePkg::regIdx    writeRegM,
    output mipsPipePkg::regIdx    writeRegE
);

    mipsPipePkg::dataWord srcAE, srcBE, writeDataE, aluOutE;

    function automatic mipsPipePkg::dataWord fwdMux(mipsPipePkg::fwdSel sel,
                                                   mipsPipePkg::dataWord regVal);
        case (sel)
            mipsPipePkg::fwdMem: return aluOutM;
            mipsPipePkg::fwdWb:  return resultW;
            default:             return regVal;
        endcase
    endfunction

    assign srcAE      = fwdMux(forwardAE, rd1E);
    assign writeDataE = fwdMux(forwardBE, rd2E); // also the store data
    assign srcBE      = aluSrcE ? signImmE : writeDataE;
    assign writeRegE  = regDstE ? rdE : rtE;

    always_comb begin
        case (aluControlE)
            mipsPipePkg::aluSub: aluOutE = srcAE - srcBE;
            mipsPipePkg::aluAnd: aluOutE = srcAE & srcBE;
            mipsPipePkg::aluOr:  aluOutE = srcAE | srcBE;
            mipsPipePkg::aluSlt: aluOutE = {31'd0, $signed(srcAE) < $signed(srcBE)};
            default:             aluOutE = srcAE + srcBE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX/MEM register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rstN) {regWriteM, memToRegM, memWriteM} <= '0;
        else       {regWriteM, memToRegM, memWriteM} <= {regWriteE, memToRegE, memWriteE};
    end

    always_ff @(posedge clk) begin
        aluOutM    <= aluOutE;
        writeDataM <= writeDataE;
        writeRegM  <= writeRegE;
    end

endmodule

/* fetchStage.sv */
`timescale 1ns/1ps
`include "mipsCfg.svh"

module fetchStage (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         stallF,
    input  logic                         stallD,
    input  logic                         pcSrcD,
    input  mipsPipePkg::dataWord         pcBranchD,
    input  logic                         imemWe,
    input  logic [`IMEM_ADDR_BITS-1:0]   imemAddr,
    input  mipsIsaPkg::instrWord         imemData,
    output mipsIsaPkg::instrWord         instrD,
    output mipsPipePkg::dataWord         pcPlus4D
);

    mipsIsaPkg::instrWord imem [2**`IMEM_ADDR_BITS];
    mipsPipePkg::dataWord pcF;
    mipsPipePkg::dataWord pcPlus4F;
    mipsPipePkg::dataWord pcNextF;

    assign pcPlus4F = pcF + 32'd4;
    assign pcNextF  = pcSrcD ? pcBranchD : pcPlus4F; // branch resolves in decode

    always_ff @(posedge clk) begin
        if (imemWe) imem[imemAddr] <= imemData; // program load port
    end

    always_ff @(posedge clk) begin
        if (!rstN) pcF <= `RESET_PC;
        else if (!stallF) pcF <= pcNextF;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // IF/ID register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrD <= '0;
        end else if (!stallD) begin
            instrD   <= pcSrcD ? '0 : imem[pcF[`IMEM_ADDR_BITS+1:2]]; // squash slot after taken beq
            pcPlus4D <= pcPlus4F;
        end
    end

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    input  mipsPipePkg::regIdx  rsD,
    input  mipsPipePkg::regIdx  rtD,
    input  mipsPipePkg::regIdx  rsE,
    input  mipsPipePkg::regIdx  rtE,
    input  mipsPipePkg::regIdx  writeRegE,
    input  mipsPipePkg::regIdx  writeRegM,
    input  mipsPipePkg::regIdx  writeRegW,
    input  logic                regWriteE,
    input  logic                memToRegE,
    input  logic                regWriteM,
    input  logic                memToRegM,
    input  logic                regWriteW,
    input  logic                branchD,
    output logic                stallF,
    output logic                stallD,
    output logic                flushE,
    output logic                forwardAD,
    output logic                forwardBD,
    output mipsPipePkg::fwdSel  forwardAE,
    output mipsPipePkg::fwdSel  forwardBE
);

    logic lwStall, branchStall;

    // memory stage wins over writeback, r0 never forwarded
    function automatic mipsPipePkg::fwdSel fwdFrom(mipsPipePkg::regIdx src);
        if (src != '0 && regWriteM && src == writeRegM) return mipsPipePkg::fwdMem;
        if (src != '0 && regWriteW && src == writeRegW) return mipsPipePkg::fwdWb;
        return mipsPipePkg::fwdNone;
    endfunction

    assign forwardAE = fwdFrom(rsE);
    assign forwardBE = fwdFrom(rtE);

    assign forwardAD = rsD != '0 && regWriteM && rsD == writeRegM;
    assign forwardBD = rtD != '0 && regWriteM && rtD == writeRegM;

    assign lwStall = memToRegE && (rtE == rsD || rtE == rtD);
    assign branchStall = branchD &&
        ((regWriteE && (writeRegE == rsD || writeRegE == rtD)) ||
         (memToRegM && (writeRegM == rsD || writeRegM == rtD))); // load still in memory

    assign stallF = lwStall || branchStall;
    assign stallD = stallF;
    assign flushE = stallF;

endmodule

/* memoryStage.sv */
`timescale 1ns/1ps
`include "mipsCfg.svh"

module memoryStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  regWriteM,
    input  logic                  memToRegM,
    input  logic                  memWriteM,
    input  mipsPipePkg::dataWord  aluOutM,
    input  mipsPipePkg::dataWord  writeDataM,
    input  mipsPipePkg::regIdx    writeRegM,
    output logic                  regWriteW,
    output logic                  memToRegW,
    output mipsPipePkg::dataWord  readDataW,
    output mipsPipePkg::dataWord  aluOutW,
    output mipsPipePkg::regIdx    writeRegW
);

    mipsPipePkg::dataWord dmem [2**`DMEM_ADDR_BITS];
    mipsPipePkg::dataWord readDataM;
    logic [`DMEM_ADDR_BITS-1:0] dAddr;

    assign dAddr     = aluOutM[`DMEM_ADDR_BITS+1:2]; // word addressed
    assign readDataM = dmem[dAddr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**`DMEM_ADDR_BITS; i++) dmem[i] <= '0;
        end else if (memWriteM) begin
            dmem[dAddr] <= writeDataM;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (!rstN) {regWriteW, memToRegW} <= '0;
        else       {regWriteW, memToRegW} <= {regWriteM, memToRegM};
    end

    always_ff @(posedge clk) begin
        readDataW <= readDataM;
        aluOutW   <= aluOutM;
        writeRegW <= writeRegM;
    end

endmodule

/* mipsCfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory sizes, in word-address bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define IMEM_ADDR_BITS 6
`define DMEM_ADDR_BITS 6

`define RESET_PC 32'h0000_0000

`endif

/* mipsCore.f */
+incdir+.
mipsIsaPkg.sv
mipsPipePkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
mipsCore.sv
mipsCoreTb.sv

/* mipsCore.sv */
`timescale 1ns/1ps
`include "mipsCfg.svh"

module mipsCore (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        imemWe,
    input  logic [`IMEM_ADDR_BITS-1:0]  imemAddr,
    input  mipsIsaPkg::instrWord        imemData,
    output logic                        wbValid,
    output mipsPipePkg::regIdx          wbReg,
    output mipsPipePkg::dataWord        wbData
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage-to-stage wires
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mipsIsaPkg::instrWord instrD;
    mipsPipePkg::dataWord pcPlus4D, pcBranchD;
    mipsPipePkg::dataWord rd1E, rd2E, signImmE;
    mipsPipePkg::dataWord aluOutM, writeDataM;
    mipsPipePkg::dataWord readDataW, aluOutW, resultW;
    mipsPipePkg::regIdx   rsD, rtD, rsE, rtE, rdE;
    mipsPipePkg::regIdx   writeRegE, writeRegM, writeRegW;
    mipsPipePkg::aluOp    aluControlE;
    mipsPipePkg::fwdSel   forwardAE, forwardBE;
    logic pcSrcD, branchD;
    logic regWriteE, memToRegE, memWriteE, aluSrcE, regDstE;
    logic regWriteM, memToRegM, memWriteM;
    logic regWriteW, memToRegW;
    logic stallF, stallD, flushE, forwardAD, forwardBD;

    fetchStage fetch (
        .clk(clk), .rstN(rstN), .stallF(stallF), .stallD(stallD),
        .pcSrcD(pcSrcD), .pcBranchD(pcBranchD),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .instrD(instrD), .pcPlus4D(pcPlus4D)
    );

    decodeStage decode (
        .clk(clk), .rstN(rstN), .instrD(instrD), .pcPlus4D(pcPlus4D),
        .regWriteW(regWriteW), .writeRegW(writeRegW), .resultW(resultW),
        .aluOutM(aluOutM), .forwardAD(forwardAD), .forwardBD(forwardBD), .flushE(flushE),
        .pcSrcD(pcSrcD), .pcBranchD(pcBranchD), .rsD(rsD), .rtD(rtD), .branchD(branchD),
        .regWriteE(regWriteE), .memToRegE(memToRegE), .memWriteE(memWriteE),
        .aluSrcE(aluSrcE), .regDstE(regDstE), .aluControlE(aluControlE),
        .rd1E(rd1E), .rd2E(rd2E), .signImmE(signImmE),
        .rsE(rsE), .rtE(rtE), .rdE(rdE)
    );

    executeStage execute (
        .clk(clk), .rstN(rstN),
        .regWriteE(regWriteE), .memToRegE(memToRegE), .memWriteE(memWriteE),
        .aluSrcE(aluSrcE), .regDstE(regDstE), .aluControlE(aluControlE),
        .rd1E(rd1E), .rd2E(rd2E), .signImmE(signImmE), .rtE(rtE), .rdE(rdE),
        .forwardAE(forwardAE), .forwardBE(forwardBE), .resultW(resultW),
        .regWriteM(regWriteM), .memToRegM(memToRegM), .memWriteM(memWriteM),
        .aluOutM(aluOutM), .writeDataM(writeDataM), .writeRegM(writeRegM),
        .writeRegE(writeRegE)
    );

    memoryStage memory (
        .clk(clk), .rstN(rstN),
        .regWriteM(regWriteM), .memToRegM(memToRegM), .memWriteM(memWriteM),
        .aluOutM(aluOutM), .writeDataM(writeDataM), .writeRegM(writeRegM),
        .regWriteW(regWriteW), .memToRegW(memToRegW),
        .readDataW(readDataW), .aluOutW(aluOutW), .writeRegW(writeRegW)
    );

    hazardUnit hazards (
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
        .regWriteE(regWriteE), .memToRegE(memToRegE),
        .regWriteM(regWriteM), .memToRegM(memToRegM),
        .regWriteW(regWriteW), .branchD(branchD),
        .stallF(stallF), .stallD(stallD), .flushE(flushE),
        .forwardAD(forwardAD), .forwardBD(forwardBD),
        .forwardAE(forwardAE), .forwardBE(forwardBE)
    );

    // writeback select and commit port
    assign resultW = memToRegW ? readDataW : aluOutW;
    assign wbValid = regWriteW && writeRegW != '0; // r0 writes are dropped
    assign wbReg   = writeRegW;
    assign wbData  = resultW;

endmodule

/* mipsCoreTb.sv */
`timescale 1ns/1ps
`include "mipsCfg.svh"

module mipsCoreTb;

    localparam int numRows     = 5;
    localparam int maxLen      = 16;
    localparam int drainCycles = 6; // quiet window after the last expected commit

    logic                       clk = 1'b0;
    logic                       rstN;
    logic                       imemWe;
    logic [`IMEM_ADDR_BITS-1:0] imemAddr;
    mipsIsaPkg::instrWord       imemData;
    logic                       wbValid;
    mipsPipePkg::regIdx         wbReg;
    mipsPipePkg::dataWord       wbData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program table and expected commits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mipsIsaPkg::instrWord progMem [numRows][maxLen];
    int                   progLen [numRows];
    mipsPipePkg::regIdx   expReg [numRows][maxLen];
    mipsPipePkg::dataWord expData [numRows][maxLen];
    int                   expCount [numRows];

    int mismatchCount = 0;
    int otherCount    = 0;
    int cycleCount    = 0;
    int cycleLimit    = 0;
    int curRow        = 0;
    int seenCount     = 0;
    int rngState      = 51;

    mipsCore DUT (
        .clk(clk), .rstN(rstN),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout in row %0d: got %0d of %0d commits after %0d cycles",
                     curRow, seenCount, expCount[curRow], cycleCount);
            $display("errors: %0d mismatches, %0d other", mismatchCount, otherCount + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic int nextRandom();
        int x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic mipsIsaPkg::instrWord encR(mipsIsaPkg::funct fn, int rd, int rs, int rt);
        return {mipsIsaPkg::opRType, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic mipsIsaPkg::instrWord encI(mipsIsaPkg::opcode op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic addInstr(input int row, input mipsIsaPkg::instrWord word);
        progMem[row][progLen[row]] = word;
        progLen[row]++;
    endtask

    task automatic buildTable();
        foreach (progLen[r]) progLen[r] = 0;
        // dependent ALU chain with random immediates
        addInstr(0, encI(mipsIsaPkg::opAddi, 1, 0, nextRandom()));
        addInstr(0, encI(mipsIsaPkg::opAddi, 2, 0, nextRandom()));
        addInstr(0, encR(mipsIsaPkg::fnAdd, 3, 1, 2));
        addInstr(0, encR(mipsIsaPkg::fnSub, 4, 1, 3));
        addInstr(0, encR(mipsIsaPkg::fnAnd, 5, 4, 3));
        addInstr(0, encR(mipsIsaPkg::fnOr, 6, 5, 2));
        addInstr(0, encR(mipsIsaPkg::fnSlt, 7, 4, 6));
        addInstr(0, encR(mipsIsaPkg::fnSlt, 8, 6, 4));
        addInstr(0, encI(mipsIsaPkg::opAddi, 9, 7, nextRandom()));
        // store and load back with a load-use add
        addInstr(1, encI(mipsIsaPkg::opAddi, 1, 0, 32'h55));
        addInstr(1, encI(mipsIsaPkg::opAddi, 2, 0, 8));
        addInstr(1, encI(mipsIsaPkg::opSw, 1, 2, 4));
        addInstr(1, encI(mipsIsaPkg::opLw, 3, 2, 4));
        addInstr(1, encR(mipsIsaPkg::fnAdd, 4, 3, 1));
        addInstr(1, encI(mipsIsaPkg::opLw, 5, 0, 0));
        addInstr(1, encI(mipsIsaPkg::opLw, 6, 0, 12));
        // taken and not-taken beq
        addInstr(2, encI(mipsIsaPkg::opAddi, 1, 0, 5));
        addInstr(2, encI(mipsIsaPkg::opAddi, 2, 0, 5));
        addInstr(2, encI(mipsIsaPkg::opBeq, 2, 1, 1));
        addInstr(2, encI(mipsIsaPkg::opAddi, 3, 0, 99)); // skipped
        addInstr(2, encI(mipsIsaPkg::opAddi, 4, 0, 7));
        addInstr(2, encI(mipsIsaPkg::opBeq, 4, 1, 1));
        addInstr(2, encI(mipsIsaPkg::opAddi, 5, 0, 11));
        // beq operands from addi and from loads one and two back
        addInstr(3, encI(mipsIsaPkg::opAddi, 1, 0, 3));
        addInstr(3, encI(mipsIsaPkg::opAddi, 2, 0, 3));
        addInstr(3, encI(mipsIsaPkg::opBeq, 1, 2, 1));
        addInstr(3, encI(mipsIsaPkg::opAddi, 9, 0, 1)); // skipped
        addInstr(3, encI(mipsIsaPkg::opSw, 1, 0, 0));
        addInstr(3, encI(mipsIsaPkg::opLw, 3, 0, 0));
        addInstr(3, encI(mipsIsaPkg::opBeq, 1, 3, 1));
        addInstr(3, encI(mipsIsaPkg::opAddi, 9, 0, 2)); // skipped
        addInstr(3, encI(mipsIsaPkg::opAddi, 5, 0, 3));
        addInstr(3, encI(mipsIsaPkg::opLw, 4, 0, 0));
        addInstr(3, encI(mipsIsaPkg::opAddi, 6, 0, 4)); // independent, load sits in memory
        addInstr(3, encI(mipsIsaPkg::opBeq, 5, 4, 1));
        addInstr(3, encI(mipsIsaPkg::opAddi, 9, 0, 3)); // skipped
        // r0 writes and reads plus a load from reset-cleared memory
        addInstr(4, encI(mipsIsaPkg::opAddi, 0, 0, 77));
        addInstr(4, encI(mipsIsaPkg::opAddi, 1, 0, 5));
        addInstr(4, encR(mipsIsaPkg::fnAdd, 0, 1, 1));
        addInstr(4, encR(mipsIsaPkg::fnAdd, 2, 0, 1));
        addInstr(4, encI(mipsIsaPkg::opLw, 3, 0, 12));
        foreach (progLen[r]) addInstr(r, encI(mipsIsaPkg::opBeq, 0, 0, -1)); // self loop
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model that steps one instruction at a time
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic buildExpected(input int row);
        mipsPipePkg::dataWord regs [32];
        mipsPipePkg::dataWord mem [2**`DMEM_ADDR_BITS];
        mipsIsaPkg::instrWord ins;
        mipsPipePkg::dataWord a, b, imm, addr, res;
        logic [4:0] rs, rt, rd, dst;
        logic       wen, done;
        int         pc, steps;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
        expCount[row] = 0;
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && pc < progLen[row] && steps < 64) begin
            ins = progMem[row][pc];
            rs = ins[25:21];
            rt = ins[20:16];
            rd = ins[15:11];
            a = regs[rs];
            b = regs[rt];
            imm = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            wen = 1'b0;
            dst = rt;
            res = '0;
            pc++;
            steps++;
            case (ins[31:26])
                mipsIsaPkg::opRType: begin
                    wen = 1'b1;
                    dst = rd;
                    case (ins[5:0])
                        mipsIsaPkg::fnSub: res = a - b;
                        mipsIsaPkg::fnAnd: res = a & b;
                        mipsIsaPkg::fnOr:  res = a | b;
                        mipsIsaPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:           res = a + b;
                    endcase
                end
                mipsIsaPkg::opAddi: begin
                    wen = 1'b1;
                    res = addr;
                end
                mipsIsaPkg::opLw: begin
                    wen = 1'b1;
                    res = mem[addr[`DMEM_ADDR_BITS+1:2]];
                end
                mipsIsaPkg::opSw: mem[addr[`DMEM_ADDR_BITS+1:2]] = b;
                mipsIsaPkg::opBeq: begin
                    if (a == b && imm == 32'hffff_ffff) done = 1'b1; // reached the end loop
                    else if (a == b) pc = pc + $signed(imm);
                end
                default: ;
            endcase
            if (wen && dst != 5'd0) begin
                regs[dst] = res;
                expReg[row][expCount[row]] = dst;
                expData[row][expCount[row]] = res;
                expCount[row]++;
            end
        end
        if (!done) begin
            $display("reference model for row %0d never reached its end loop", row);
            otherCount++;
        end
    endtask

    task automatic checkReg(input mipsPipePkg::regIdx got, input mipsPipePkg::regIdx exp,
                            input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s wrote r%0d, expected r%0d", $time, what, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic checkData(input mipsPipePkg::dataWord got, input mipsPipePkg::dataWord exp,
                             input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s data %h, expected %h", $time, what, got, exp);
            mismatchCount++;
        end
    endtask

    // reset and load the program before following the commit port
    task automatic runRow(input int row);
        int slot;
        curRow = row;
        seenCount = 0;
        rstN = 1'b0;
        for (int i = 0; i < 3 + progLen[row]; i++) begin
            slot = i - 3;
            imemWe = (i >= 3);
            if (i >= 3) begin
                imemAddr = slot[`IMEM_ADDR_BITS-1:0];
                imemData = progMem[row][slot];
            end
            @(negedge clk);
            if (wbValid) begin
                $display("row %0d: commit seen while the core is in reset", row);
                otherCount++;
            end
        end
        imemWe = 1'b0;
        rstN = 1'b1;
        while (seenCount < expCount[row]) begin
            @(negedge clk);
            if (wbValid) begin
                checkReg(wbReg, expReg[row][seenCount],
                         $sformatf("row %0d commit %0d", row, seenCount));
                checkData(wbData, expData[row][seenCount],
                          $sformatf("row %0d commit %0d", row, seenCount));
                seenCount++;
            end
        end
        repeat (drainCycles) begin
            @(negedge clk);
            if (wbValid) begin
                $display("row %0d: extra commit to r%0d with %h", row, wbReg, wbData);
                otherCount++;
            end
        end
    endtask

    initial begin
        rstN = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        buildTable();
        for (int r = 0; r < numRows; r++) begin
            buildExpected(r);
            cycleLimit += 3 * progLen[r] + 20;
        end
        for (int r = 0; r < numRows; r++) runRow(r);
        $display("errors: %0d mismatches, %0d other", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* mipsIsaPkg.sv */
package mipsIsaPkg;

    typedef logic [31:0] instrWord;
    typedef logic [15:0] imm16;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // primary opcodes, bits 31:26
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcode;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct;

endpackage

/* mipsPipePkg.sv */
package mipsPipePkg;

    typedef logic [31:0] dataWord;
    typedef logic [4:0]  regIdx;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp;

    // operand source for the execute stage
    typedef enum logic [1:0] {
        fwdNone,
        fwdMem,
        fwdWb
    } fwdSel;

endpackage
